// File: vlog.f
+incdir+hdl
hdl/io_pkg.sv
hdl/wb_if.sv
hdl/wb_cmd_master.sv
hdl/wb_reg_slice.sv
hdl/io_regs.sv
hdl/io_top.sv
sim/tb_clkgen.sv
sim/io_top_chk.sv
sim/tb_io_top.sv

// File: sim/tb_io_top.sv
`timescale 1ns/10ps

`include "io_params.svh"

// Table-driven testbench for the I/O subsystem

module tb_io_top;
   import io_pkg::*;

   localparam int CLK_NS      = 8;
   localparam int RST_CYCLES  = 4;
   localparam int NUM_ENTRIES = 14;
   localparam int MAX_EXTRA   = 2;               // Random stall on top of the table
   localparam int MAX_STALL   = 3 + MAX_EXTRA;
   localparam int WD_NS       = (RST_CYCLES + NUM_ENTRIES * (8 + MAX_STALL)) * CLK_NS;
   localparam int SEED        = 24362;

   typedef struct {
      logic     we;
      io_addr_t addr;
      io_data_t data;
      io_sel_t  sel;
      logic     rx;        // Pin level during the access
      int       stall;     // Cycles of rsp_ready low
      io_data_t exp_rsp;
      logic     exp_tx;
      logic     exp_red;
      logic     exp_green;
   } entry_t;

   logic     CLK_I;
   logic     rst_n;
   logic     cmd_valid;
   logic     cmd_ready;
   logic     cmd_we;
   io_addr_t cmd_addr;
   io_data_t cmd_data;
   io_sel_t  cmd_sel;
   logic     rsp_valid;
   logic     rsp_ready;
   io_data_t rsp_data;
   logic     rx;
   logic     tx;
   logic     led_red;
   logic     led_green;
   logic     led_blue;
   entry_t   tbl [NUM_ENTRIES];

   tb_clkgen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(RST_CYCLES)) u_clkgen (
      .CLK_I (CLK_I),
      .rst_n (rst_n)
   );

   io_top dut (
      .CLK_I     (CLK_I),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_we    (cmd_we),
      .cmd_addr  (cmd_addr),
      .cmd_data  (cmd_data),
      .cmd_sel   (cmd_sel),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data),
      .rx        (rx),
      .tx        (tx),
      .led_red   (led_red),
      .led_green (led_green),
      .led_blue  (led_blue)
   );

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("** Error at time %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
         $display("Checks failed");
         $fatal(1, "run stopped at first mismatch");
      end
   endtask

   task automatic set_entry(input int idx, input logic we, input io_addr_t addr,
                            input io_data_t data, input io_sel_t sel, input logic rxv,
                            input int stall);
      tbl[idx].we    = we;
      tbl[idx].addr  = addr;
      tbl[idx].data  = data;
      tbl[idx].sel   = sel;
      tbl[idx].rx    = rxv;
      tbl[idx].stall = stall;
   endtask

   task automatic build_table();
      //        idx we addr          data          sel   rx stall
      set_entry(0,  0, 32'h0000_0000, 32'h0000_0000, 4'hF, 0, 0);  // Reset values
      set_entry(1,  1, 32'h0000_0004, 32'h0000_0003, 4'hF, 0, 1);  // Red and green on
      set_entry(2,  0, 32'h0000_0004, 32'h0000_0000, 4'hF, 1, 2);
      set_entry(3,  1, 32'h0000_0008, 32'h0000_0000, 4'h1, 1, 0);  // Tx low
      set_entry(4,  1, 32'h0000_0004, 32'h0000_0002, 4'hF, 0, 1);
      set_entry(5,  1, 32'h0000_000C, 32'h0000_0001, 4'h1, 0, 3);  // Both registers
      set_entry(6,  1, 32'h0000_000C, 32'h0000_0002, 4'hE, 1, 0);  // Lane 0 off
      set_entry(7,  0, 32'h0000_0000, 32'h0000_0000, 4'hF, 1, 0);
      set_entry(8,  1, 32'h0000_0008, 32'hFFFF_FFFE, 4'hF, 0, 2);
      set_entry(9,  1, 32'h0000_0004, 32'h0000_0000, 4'h1, 0, 2);
      set_entry(10, 0, 32'h0000_000C, 32'h0000_0000, 4'hF, 1, 1);
      set_entry(11, 1, 32'h0000_0008, 32'h0000_0001, 4'hF, 1, 1);
      set_entry(12, 0, 32'h0000_0004, 32'h0000_0001, 4'hF, 0, 3);  // Read ignores data
      set_entry(13, 1, 32'h0000_0014, 32'h0000_0003, 4'h1, 0, 0);
   endtask

   // Reference model of the register rules, fills the expected columns
   task automatic predict_all();
      logic red;
      logic green;
      logic txv;
      red   = 1'b0;
      green = 1'b0;
      txv   = 1'b1;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         if (tbl[i].we && tbl[i].sel[0]) begin
            if (tbl[i].addr[`IO_LED_BIT]) begin
               red   = tbl[i].data[0];
               green = tbl[i].data[1];
            end
            if (tbl[i].addr[`IO_TX_BIT]) begin
               txv = tbl[i].data[0];
            end
         end
         tbl[i].exp_rsp      = '0;
         tbl[i].exp_rsp[3:0] = {txv, green, red, tbl[i].rx};
         tbl[i].exp_tx       = txv;
         tbl[i].exp_red      = red;
         tbl[i].exp_green    = green;
      end
   endtask

   task automatic drive_cmd(input int idx);
      cmd_valid <= 1'b1;
      cmd_we    <= tbl[idx].we;
      cmd_addr  <= tbl[idx].addr;
      cmd_data  <= tbl[idx].data;
      cmd_sel   <= tbl[idx].sel;
      rx        <= tbl[idx].rx;   // Held until the next command
   endtask

   // Bound assertion failures end the run like any other mismatch
   always @(negedge CLK_I) begin
      if (rst_n) begin
         check_value(dut.u_chk.fail_cnt, 0, "bound assertion failures");
      end
   end

   initial begin
      #(WD_NS);
      $display("Timeout: the run did not finish within %0d ns, a handshake hung", WD_NS);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      int stall;
      int lat;
      void'($urandom(SEED));
      cmd_valid = 1'b0;
      cmd_we    = 1'b0;
      cmd_addr  = '0;
      cmd_data  = '0;
      cmd_sel   = '0;
      rsp_ready = 1'b0;
      rx        = 1'b0;
      build_table();
      predict_all();
      wait (rst_n === 1'b1);
      @(negedge CLK_I);
      check_value(tx, 1'b1, "tx after reset");
      check_value(led_red, 1'b0, "led_red after reset");
      check_value(led_green, 1'b0, "led_green after reset");
      check_value(cmd_ready, 1'b1, "cmd_ready after reset");
      check_value(rsp_valid, 1'b0, "rsp_valid after reset");
      @(posedge CLK_I);
      drive_cmd(0);
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         @(negedge CLK_I);
         while (!cmd_ready) @(negedge CLK_I);   // Accepted on the next edge
         @(posedge CLK_I);
         cmd_valid <= 1'b0;
         lat = 0;
         @(negedge CLK_I);
         while (!rsp_valid) begin
            lat++;
            @(negedge CLK_I);
         end
         check_value(lat, 3, "command to response cycles");
         check_value(rsp_data, tbl[i].exp_rsp, "rsp_data");
         check_value(tx, tbl[i].exp_tx, "tx");
         check_value(led_red, tbl[i].exp_red, "led_red");
         check_value(led_green, tbl[i].exp_green, "led_green");
         check_value(led_blue, tbl[i].rx, "led_blue");
         stall = tbl[i].stall + ($urandom % (MAX_EXTRA + 1));
         @(posedge CLK_I);
         if (i + 1 < NUM_ENTRIES) begin
            drive_cmd(i + 1);             // Waits behind the pending response
         end
         repeat (stall) begin
            @(negedge CLK_I);
            check_value(rsp_valid, 1'b1, "rsp_valid under stall");
            check_value(rsp_data, tbl[i].exp_rsp, "rsp_data under stall");
            check_value(cmd_ready, 1'b0, "cmd_ready under stall");
            @(posedge CLK_I);
         end
         rsp_ready <= 1'b1;
         @(negedge CLK_I);
         check_value(rsp_valid, 1'b1, "rsp_valid at transfer");
         @(posedge CLK_I);
         rsp_ready <= 1'b0;
      end
      repeat (2) @(posedge CLK_I);
      if (dut.u_chk.fail_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: sim/io_top_chk.sv
`timescale 1ns/10ps

// Protocol checks on the command and response ports and the master side bus

module io_top_chk (
   input logic             CLK_I,
   input logic             rst_n,
   input logic             cmd_valid,
   input logic             cmd_ready,
   input logic             cmd_we,
   input io_pkg::io_addr_t cmd_addr,
   input io_pkg::io_data_t cmd_data,
   input io_pkg::io_sel_t  cmd_sel,
   input logic             rsp_valid,
   input logic             rsp_ready,
   input io_pkg::io_data_t rsp_data,
   input logic             m_stb,     // Master strobe
   input logic             m_ack      // Registered ack from the slice
);

   int unsigned fail_cnt = 0;         // Read by the testbench

   // Command and fields held until accepted
   a_cmd_hold: assert property (@(posedge CLK_I) disable iff (!rst_n)
      cmd_valid && !cmd_ready |=> cmd_valid && $stable({cmd_we, cmd_addr, cmd_data, cmd_sel}))
      else begin
         $error("command changed while waiting for cmd_ready");
         fail_cnt++;
      end

   // Response rises on the third edge after the transfer
   a_rsp_lat: assert property (@(posedge CLK_I) disable iff (!rst_n)
      cmd_valid && cmd_ready |=> !rsp_valid [*3] ##1 rsp_valid)
      else begin
         $error("response latency is not 3 cycles");
         fail_cnt++;
      end

   // Back-pressure keeps the response frozen
   a_rsp_hold: assert property (@(posedge CLK_I) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
      else begin
         $error("response changed under back-pressure");
         fail_cnt++;
      end

   a_busy: assert property (@(posedge CLK_I) disable iff (!rst_n)
      rsp_valid |-> !cmd_ready)       // One transaction at a time
      else begin
         $error("cmd_ready high while a response is pending");
         fail_cnt++;
      end

   // Ack is one cycle and the master closes the cycle right after
   a_ack_close: assert property (@(posedge CLK_I) disable iff (!rst_n)
      m_ack |=> !m_ack && !m_stb)
      else begin
         $error("bus ack longer than one cycle or strobe not dropped");
         fail_cnt++;
      end

endmodule

bind io_top io_top_chk u_chk (
   .CLK_I     (CLK_I),
   .rst_n     (rst_n),
   .cmd_valid (cmd_valid),
   .cmd_ready (cmd_ready),
   .cmd_we    (cmd_we),
   .cmd_addr  (cmd_addr),
   .cmd_data  (cmd_data),
   .cmd_sel   (cmd_sel),
   .rsp_valid (rsp_valid),
   .rsp_ready (rsp_ready),
   .rsp_data  (rsp_data),
   .m_stb     (bus_m.stb),
   .m_ack     (bus_m.ack)
);

// File: sim/tb_clkgen.sv
`timescale 1ns/10ps

// Free running clock and power-on reset

module tb_clkgen #(
   parameter int PERIOD_NS  = 8,
   parameter int RST_CYCLES = 4    // Clock edges with reset held
) (
   output logic CLK_I,
   output logic rst_n
);

   initial begin
      CLK_I = 1'b0;
      forever #(PERIOD_NS / 2) CLK_I = ~CLK_I;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge CLK_I);
      rst_n <= 1'b1;               // Release on an edge
   end

endmodule

// File: hdl/io_top.sv
`timescale 1ns/10ps

// I/O subsystem top
// Command master, registered slice and I/O block chained over Wishbone

module io_top (
   input  logic             CLK_I,
   input  logic             rst_n,
   // Command port, stands in for the core
   input  logic             cmd_valid,
   output logic             cmd_ready,
   input  logic             cmd_we,
   input  io_pkg::io_addr_t cmd_addr,
   input  io_pkg::io_data_t cmd_data,
   input  io_pkg::io_sel_t  cmd_sel,
   // Response port
   output logic             rsp_valid,
   input  logic             rsp_ready,
   output io_pkg::io_data_t rsp_data,
   // Board pins
   input  logic             rx,
   output logic             tx,
   output logic             led_red,
   output logic             led_green,
   output logic             led_blue
);

   wb_if bus_m ();   // Master to slice
   wb_if bus_s ();   // Slice to I/O registers

   // Command to bus cycle
   wb_cmd_master u_master (
      .CLK_I     (CLK_I),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_we    (cmd_we),
      .cmd_addr  (cmd_addr),
      .cmd_data  (cmd_data),
      .cmd_sel   (cmd_sel),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data),
      .bus       (bus_m.master)
   );

   // Registered stage, breaks the ack path
   wb_reg_slice u_slice (
      .CLK_I (CLK_I),
      .rst_n (rst_n),
      .up    (bus_m.slave),
      .down  (bus_s.master)
   );

   // LED, transmit and receive pins
   io_regs u_regs (
      .CLK_I     (CLK_I),
      .rst_n     (rst_n),
      .rx        (rx),
      .bus       (bus_s.slave),
      .tx        (tx),
      .led_red   (led_red),
      .led_green (led_green),
      .led_blue  (led_blue)
   );

endmodule

// File: hdl/io_regs.sv
`timescale 1ns/10ps

`include "io_params.svh"

// RGB LED and UART transmit registers, receive pin read-back

module io_regs (
   input  logic CLK_I,
   input  logic rst_n,
   input  logic rx,          // UART receive pin, asynchronous
   wb_if.slave  bus,
   output logic tx,          // Bit-banged UART transmit
   output logic led_red,
   output logic led_green,
   output logic led_blue     // Mirrors synchronized rx
);
   import io_pkg::*;

   logic     access;         // Any strobed access
   logic     wr_en;          // Write to byte lane 0
   logic     led_wr;
   logic     tx_wr;
   logic     red_nxt;
   logic     green_nxt;
   logic     tx_nxt;
   logic     rx_meta;        // First synchronizer stage
   logic     rx_sync;        // Second stage, safe to use
   io_data_t rd_data;

   assign access = bus.cyc & bus.stb;
   assign wr_en  = access & bus.we & bus.sel[0];
   assign led_wr = wr_en & bus.adr[`IO_LED_BIT];
   assign tx_wr  = wr_en & bus.adr[`IO_TX_BIT];   // Both may hit at once

   // Values after this cycle, so a write reads back its own result
   assign red_nxt   = led_wr ? bus.dat_w[0] : led_red;
   assign green_nxt = led_wr ? bus.dat_w[1] : led_green;
   assign tx_nxt    = tx_wr  ? bus.dat_w[0] : tx;

   always_ff @(posedge CLK_I or negedge rst_n) begin
      if (!rst_n) begin
         led_red   <= 1'b0;
         led_green <= 1'b0;
         tx        <= 1'b1;     // Line idles high
      end else begin
         led_red   <= red_nxt;
         led_green <= green_nxt;
         tx        <= tx_nxt;
      end
   end

   // Two flop synchronizer on rx
   always_ff @(posedge CLK_I or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b0;
         rx_sync <= 1'b0;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   assign led_blue = rx_sync;

   // Read-back word
   always_comb begin
      rd_data    = '0;
      rd_data[0] = rx_sync;
      rd_data[1] = red_nxt;
      rd_data[2] = green_nxt;
      rd_data[3] = tx_nxt;
   end

   assign bus.dat_r = rd_data;
   assign bus.ack   = access;   // Zero wait states

endmodule

// File: hdl/wb_reg_slice.sv
`timescale 1ns/10ps

// One-deep registered slice between master and I/O block
// Request goes down one cycle late, ack and data come back one cycle late

module wb_reg_slice (
   input logic  CLK_I,
   input logic  rst_n,
   wb_if.slave  up,     // From the command master
   wb_if.master down    // To the I/O registers
);
   import io_pkg::*;

   logic     busy;       // Request taken, upstream cycle not yet closed
   logic     start;      // First cycle of an upstream strobe
   logic     dn_stb;     // Downstream cycle and strobe
   logic     dn_done;    // Downstream ack seen
   logic     ack_q;      // Registered ack toward the master
   logic     we_q;
   io_addr_t adr_q;
   io_data_t dat_w_q;
   io_sel_t  sel_q;
   io_data_t dat_r_q;

   assign start   = up.cyc & up.stb & ~busy;
   assign dn_done = dn_stb & down.ack;

   // Control flags
   always_ff @(posedge CLK_I or negedge rst_n) begin
      if (!rst_n) begin
         busy   <= 1'b0;
         dn_stb <= 1'b0;
         ack_q  <= 1'b0;
      end else begin
         // Busy until the master lets go of strobe
         if (start) begin
            busy <= 1'b1;
         end else if (!up.stb) begin
            busy <= 1'b0;
         end
         // Exactly one downstream strobe per upstream cycle
         if (start) begin
            dn_stb <= 1'b1;
         end else if (down.ack) begin
            dn_stb <= 1'b0;
         end
         ack_q <= dn_done;    // One cycle pulse back up
      end
   end

   // Request register
   always_ff @(posedge CLK_I) begin
      if (start) begin
         we_q    <= up.we;
         adr_q   <= up.adr;
         dat_w_q <= up.dat_w;
         sel_q   <= up.sel;
      end
   end

   // Read data register, loaded with the ack
   always_ff @(posedge CLK_I) begin
      if (dn_done) begin
         dat_r_q <= down.dat_r;
      end
   end

   // Downstream side
   assign down.cyc   = dn_stb;
   assign down.stb   = dn_stb;
   assign down.we    = we_q;
   assign down.adr   = adr_q;
   assign down.dat_w = dat_w_q;
   assign down.sel   = sel_q;

   // Upstream side
   assign up.ack   = ack_q;
   assign up.dat_r = dat_r_q;

endmodule

// File: hdl/wb_cmd_master.sv
`timescale 1ns/10ps

// Turns one command into one Wishbone classic cycle

module wb_cmd_master (
   input  logic             CLK_I,
   input  logic             rst_n,
   // Command port
   input  logic             cmd_valid,
   output logic             cmd_ready,
   input  logic             cmd_we,
   input  io_pkg::io_addr_t cmd_addr,
   input  io_pkg::io_data_t cmd_data,
   input  io_pkg::io_sel_t  cmd_sel,
   // Response port
   output logic             rsp_valid,
   input  logic             rsp_ready,
   output io_pkg::io_data_t rsp_data,
   // Bus toward the slice
   wb_if.master             bus
);
   import io_pkg::*;

   mst_state_t state;
   mst_state_t state_nxt;
   logic       cmd_xfer;    // Command accepted this edge
   logic       bus_done;    // Ack seen in bus phase
   logic       req_we;
   io_addr_t   req_adr;
   io_data_t   req_dat;
   io_sel_t    req_sel;
   io_data_t   rsp_q;

   assign cmd_ready = (state == MST_IDLE);    // Only idle takes commands
   assign rsp_valid = (state == MST_RESP);
   assign cmd_xfer  = cmd_valid & cmd_ready;
   assign bus_done  = (state == MST_BUS) & bus.ack;

   // Next state
   always_comb begin
      state_nxt = state;
      case (state)
         MST_IDLE: begin
            if (cmd_valid) begin
               state_nxt = MST_BUS;
            end
         end
         MST_BUS: begin
            if (bus.ack) begin
               state_nxt = MST_RESP;   // Drop strobe next cycle
            end
         end
         MST_RESP: begin
            if (rsp_ready) begin
               state_nxt = MST_IDLE;
            end
         end
         default: state_nxt = MST_IDLE;
      endcase
   end

   always_ff @(posedge CLK_I or negedge rst_n) begin
      if (!rst_n) begin
         state <= MST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Request fields, frozen for the whole bus cycle
   always_ff @(posedge CLK_I) begin
      if (cmd_xfer) begin
         req_we  <= cmd_we;
         req_adr <= cmd_addr;
         req_dat <= cmd_data;
         req_sel <= cmd_sel;
      end
   end

   // Read data held until the response is taken
   always_ff @(posedge CLK_I) begin
      if (bus_done) begin
         rsp_q <= bus.dat_r;
      end
   end

   assign rsp_data = rsp_q;

   // Cycle and strobe straight from the state register
   assign bus.cyc   = (state == MST_BUS);
   assign bus.stb   = (state == MST_BUS);
   assign bus.we    = req_we;
   assign bus.adr   = req_adr;
   assign bus.dat_w = req_dat;
   assign bus.sel   = req_sel;

endmodule

// File: hdl/wb_if.sv
`timescale 1ns/10ps

interface wb_if;
   import io_pkg::*;

   // Request side, driven by the master
   logic     cyc;    // Cycle in progress
   logic     stb;    // Strobe, held until ack
   logic     we;     // Write enable
   io_addr_t adr;
   io_data_t dat_w;
   io_sel_t  sel;

   // Response side, driven by the slave
   io_data_t dat_r;
   logic     ack;    // Single cycle pulse

   modport master (
      output cyc, stb, we, adr, dat_w, sel,
      input  dat_r, ack
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w, sel,
      output dat_r, ack
   );

endinterface

// File: hdl/io_pkg.sv
`include "io_params.svh"

package io_pkg;

   // Bus vectors
   typedef logic [`IO_ADDR_W-1:0] io_addr_t;  // Byte address
   typedef logic [`IO_DATA_W-1:0] io_data_t;  // Write and read data
   typedef logic [`IO_SEL_W-1:0]  io_sel_t;   // Byte lane selects

   // Command master FSM
   typedef enum logic [1:0] {
      MST_IDLE = 2'd0,  // Waiting for a command
      MST_BUS  = 2'd1,  // Bus cycle open, waiting for ack
      MST_RESP = 2'd2   // Response held until taken
   } mst_state_t;

   // Encoding 2'd3 is never entered

endpackage

// File: hdl/io_params.svh
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// Wishbone bus widths
`define IO_ADDR_W 32
`define IO_DATA_W 32
`define IO_SEL_W  4   // One select bit per byte lane

// I/O register decode, one address bit per register
`define IO_LED_BIT 2  // RGB LED register
`define IO_TX_BIT  3  // UART transmit bit

// Both bits set in one address hits both registers

`endif
